//--- x86_dec_pkg.sv
package x86_dec_pkg;

    typedef logic [7:0]   byte_t;        // one instruction byte
    typedef logic [127:0] packet_t;      // fetch packet, first byte in [127:120]
    typedef logic [2:0]   seg_t;         // encoded segment number
    typedef logic [5:0]   seg_onehot_t;  // one bit per segment override
    typedef logic [1:0]   pfx_count_t;   // prefix count as a sum
    typedef logic [3:0]   pfx_onehot_t;  // bit n set means n prefixes

    localparam int MAX_PREFIXES = 3;

    // legacy prefix codes
    localparam byte_t PFX_REP    = 8'hF3;
    localparam byte_t PFX_CS     = 8'h2E;
    localparam byte_t PFX_SS     = 8'h36;
    localparam byte_t PFX_DS     = 8'h3E;
    localparam byte_t PFX_ES     = 8'h26;
    localparam byte_t PFX_FS     = 8'h64;
    localparam byte_t PFX_GS     = 8'h65;
    localparam byte_t PFX_OPSIZE = 8'h66;

    // bit positions inside seg_onehot_t
    localparam int OH_CS = 0;
    localparam int OH_SS = 1;
    localparam int OH_DS = 2;
    localparam int OH_ES = 3;
    localparam int OH_FS = 4;
    localparam int OH_GS = 5;

    // segment numbers as carried in seg_t
    localparam seg_t SEG_ES = 3'd0;
    localparam seg_t SEG_CS = 3'd1;
    localparam seg_t SEG_SS = 3'd2;
    localparam seg_t SEG_DS = 3'd3;  // default segment
    localparam seg_t SEG_FS = 3'd4;
    localparam seg_t SEG_GS = 3'd5;

endpackage

//--- prefix_cmp.sv
`timescale 1ns/10ps

module prefix_cmp (
    input  x86_dec_pkg::byte_t       prefix,
    output logic                     is_rep,
    output x86_dec_pkg::seg_onehot_t seg_override,  // onehot, at most one bit
    output logic                     is_opsize_override
);

    // codes are all distinct, so at most one output goes high

    always_comb begin
        is_rep             = (prefix == x86_dec_pkg::PFX_REP);
        is_opsize_override = (prefix == x86_dec_pkg::PFX_OPSIZE);

        seg_override                     = '0;
        seg_override[x86_dec_pkg::OH_CS] = (prefix == x86_dec_pkg::PFX_CS);
        seg_override[x86_dec_pkg::OH_SS] = (prefix == x86_dec_pkg::PFX_SS);
        seg_override[x86_dec_pkg::OH_DS] = (prefix == x86_dec_pkg::PFX_DS);
        seg_override[x86_dec_pkg::OH_ES] = (prefix == x86_dec_pkg::PFX_ES);
        seg_override[x86_dec_pkg::OH_FS] = (prefix == x86_dec_pkg::PFX_FS);
        seg_override[x86_dec_pkg::OH_GS] = (prefix == x86_dec_pkg::PFX_GS);
    end

endmodule

//--- prefix_decode.sv
`timescale 1ns/10ps

module prefix_decode (
    input  x86_dec_pkg::byte_t       prefix1,  // packet[127:120]
    input  x86_dec_pkg::byte_t       prefix2,
    input  x86_dec_pkg::byte_t       prefix3,
    output logic                     is_rep,
    output logic                     is_opsize_override,
    output x86_dec_pkg::seg_t        seg,
    output x86_dec_pkg::pfx_count_t  num_prefixes,
    output x86_dec_pkg::pfx_onehot_t num_prefixes_onehot
);

    localparam int N = x86_dec_pkg::MAX_PREFIXES;

    x86_dec_pkg::byte_t       pfx_byte [N];
    x86_dec_pkg::seg_onehot_t seg_m    [N];
    logic [N-1:0]             rep_m;
    logic [N-1:0]             opsize_m;
    logic [N-1:0]             is_pfx;  // byte matches any prefix code
    logic [N-1:0]             qual;    // byte is part of the leading run

    // onehot override to segment number
    function automatic x86_dec_pkg::seg_t seg_encode(input x86_dec_pkg::seg_onehot_t oh);
        x86_dec_pkg::seg_t s;
        s = x86_dec_pkg::SEG_DS;
        if (oh[x86_dec_pkg::OH_CS]) s = x86_dec_pkg::SEG_CS;
        if (oh[x86_dec_pkg::OH_SS]) s = x86_dec_pkg::SEG_SS;
        if (oh[x86_dec_pkg::OH_ES]) s = x86_dec_pkg::SEG_ES;
        if (oh[x86_dec_pkg::OH_FS]) s = x86_dec_pkg::SEG_FS;
        if (oh[x86_dec_pkg::OH_GS]) s = x86_dec_pkg::SEG_GS;
        return s;
    endfunction

    assign pfx_byte[0] = prefix1;
    assign pfx_byte[1] = prefix2;
    assign pfx_byte[2] = prefix3;

    for (genvar i = 0; i < N; i++) begin : g_cmp
        prefix_cmp i_prefix_cmp (
            .prefix             (pfx_byte[i]),
            .is_rep             (rep_m[i]),
            .seg_override       (seg_m[i]),
            .is_opsize_override (opsize_m[i])
        );
        assign is_pfx[i] = rep_m[i] | opsize_m[i] | (|seg_m[i]);
    end

    always_comb begin
        // run stops at the first non-prefix byte
        qual[0] = is_pfx[0];
        for (int i = 1; i < N; i++) begin
            qual[i] = qual[i-1] & is_pfx[i];
        end

        is_rep             = |(rep_m & qual);
        is_opsize_override = |(opsize_m & qual);

        seg          = x86_dec_pkg::SEG_DS;
        num_prefixes = '0;
        for (int i = 0; i < N; i++) begin
            if (qual[i] && (|seg_m[i])) begin
                seg = seg_encode(seg_m[i]);  // later override wins
            end
            num_prefixes = num_prefixes + x86_dec_pkg::pfx_count_t'(qual[i]);
        end

        num_prefixes_onehot = x86_dec_pkg::pfx_onehot_t'(1) << num_prefixes;
    end

endmodule

//--- opcode_align.sv
`timescale 1ns/10ps

module opcode_align (
    input  x86_dec_pkg::packet_t     packet,
    input  x86_dec_pkg::pfx_onehot_t num_prefixes_onehot,
    output x86_dec_pkg::byte_t       opcode,
    output x86_dec_pkg::byte_t       modrm
);

    localparam int N     = x86_dec_pkg::MAX_PREFIXES;
    localparam int LANES = N + 2;  // opcode can sit at lane N, modrm one after

    localparam int PKT_W = $bits(x86_dec_pkg::packet_t);

    x86_dec_pkg::byte_t lane [LANES];

    // lane 0 is the first instruction byte, at the top of the packet
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign lane[i] = packet[PKT_W-1-8*i -: 8];
    end

    // and-or mux, select is onehot
    always_comb begin
        opcode = '0;
        modrm  = '0;
        for (int n = 0; n <= N; n++) begin
            opcode = opcode | (lane[n]   & {8{num_prefixes_onehot[n]}});
            modrm  = modrm  | (lane[n+1] & {8{num_prefixes_onehot[n]}});
        end
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic                     out_ready,
    output logic                     out_valid,

    input  logic                     d_is_rep,
    input  logic                     d_is_opsize_override,
    input  x86_dec_pkg::seg_t        d_seg,
    input  x86_dec_pkg::pfx_count_t  d_num_prefixes,
    input  x86_dec_pkg::pfx_onehot_t d_num_prefixes_onehot,
    input  x86_dec_pkg::byte_t       d_opcode,
    input  x86_dec_pkg::byte_t       d_modrm,

    output logic                     q_is_rep,
    output logic                     q_is_opsize_override,
    output x86_dec_pkg::seg_t        q_seg,
    output x86_dec_pkg::pfx_count_t  q_num_prefixes,
    output x86_dec_pkg::pfx_onehot_t q_num_prefixes_onehot,
    output x86_dec_pkg::byte_t       q_opcode,
    output x86_dec_pkg::byte_t       q_modrm
);

    logic full;  // slot holds a result
    logic load;

    // slot frees up in the same cycle it is drained
    assign in_ready  = ~full | out_ready;
    assign load      = in_valid & in_ready;
    assign out_valid = full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;  // taken, nothing new
        end
    end

    // payload only moves on an accepted input
    always_ff @(posedge clk) begin
        if (load) begin
            q_is_rep              <= d_is_rep;
            q_is_opsize_override  <= d_is_opsize_override;
            q_seg                 <= d_seg;
            q_num_prefixes        <= d_num_prefixes;
            q_num_prefixes_onehot <= d_num_prefixes_onehot;
            q_opcode              <= d_opcode;
            q_modrm               <= d_modrm;
        end
    end

endmodule

//--- x86_decode_top.sv
`timescale 1ns/10ps

module x86_decode_top (
    input  logic                     clk,
    input  logic                     arst_n,

    input  x86_dec_pkg::packet_t     packet,
    input  logic                     in_valid,
    output logic                     in_ready,

    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     is_rep,
    output logic                     is_opsize_override,
    output x86_dec_pkg::seg_t        seg,
    output x86_dec_pkg::pfx_count_t  num_prefixes,
    output x86_dec_pkg::pfx_onehot_t num_prefixes_onehot,
    output x86_dec_pkg::byte_t       opcode,
    output x86_dec_pkg::byte_t       modrm
);

    // combinational decode results, before the register
    logic                     dec_is_rep;
    logic                     dec_is_opsize_override;
    x86_dec_pkg::seg_t        dec_seg;
    x86_dec_pkg::pfx_count_t  dec_num_prefixes;
    x86_dec_pkg::pfx_onehot_t dec_num_prefixes_onehot;
    x86_dec_pkg::byte_t       dec_opcode;
    x86_dec_pkg::byte_t       dec_modrm;

    prefix_decode i_prefix_decode (
        .prefix1             (packet[127:120]),
        .prefix2             (packet[119:112]),
        .prefix3             (packet[111:104]),
        .is_rep              (dec_is_rep),
        .is_opsize_override  (dec_is_opsize_override),
        .seg                 (dec_seg),
        .num_prefixes        (dec_num_prefixes),
        .num_prefixes_onehot (dec_num_prefixes_onehot)
    );

    opcode_align i_opcode_align (
        .packet              (packet),
        .num_prefixes_onehot (dec_num_prefixes_onehot),
        .opcode              (dec_opcode),
        .modrm               (dec_modrm)
    );

    decode_stage i_decode_stage (
        .clk                   (clk),
        .arst_n                (arst_n),
        .in_valid              (in_valid),
        .in_ready              (in_ready),
        .out_ready             (out_ready),
        .out_valid             (out_valid),
        .d_is_rep              (dec_is_rep),
        .d_is_opsize_override  (dec_is_opsize_override),
        .d_seg                 (dec_seg),
        .d_num_prefixes        (dec_num_prefixes),
        .d_num_prefixes_onehot (dec_num_prefixes_onehot),
        .d_opcode              (dec_opcode),
        .d_modrm               (dec_modrm),
        .q_is_rep              (is_rep),
        .q_is_opsize_override  (is_opsize_override),
        .q_seg                 (seg),
        .q_num_prefixes        (num_prefixes),
        .q_num_prefixes_onehot (num_prefixes_onehot),
        .q_opcode              (opcode),
        .q_modrm               (modrm)
    );

endmodule

//--- x86_decode_props.sv
`timescale 1ns/10ps

module x86_decode_props (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic                     is_rep,
    input logic                     is_opsize_override,
    input x86_dec_pkg::seg_t        seg,
    input x86_dec_pkg::pfx_count_t  num_prefixes,
    input x86_dec_pkg::pfx_onehot_t num_prefixes_onehot,
    input x86_dec_pkg::byte_t       opcode,
    input x86_dec_pkg::byte_t       modrm
);

    logic [26:0] fields;  // whole output payload

    assign fields = {is_rep, is_opsize_override, seg, num_prefixes,
                     num_prefixes_onehot, opcode, modrm};

    // stalled result holds until taken
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(fields)
    ) else $error("outputs changed while out_valid was high and out_ready low");

    a_onehot_count: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> $onehot(num_prefixes_onehot)
    ) else $error("num_prefixes_onehot is not one-hot while out_valid is high");

    a_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind x86_decode_top x86_decode_props i_x86_decode_props (
    .clk                 (clk),
    .arst_n              (arst_n),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .is_rep              (is_rep),
    .is_opsize_override  (is_opsize_override),
    .seg                 (seg),
    .num_prefixes        (num_prefixes),
    .num_prefixes_onehot (num_prefixes_onehot),
    .opcode              (opcode),
    .modrm               (modrm)
);

//--- x86_decode_tb.sv
`timescale 1ns/10ps

module x86_decode_tb;

    localparam int N_DIRECTED = 21;
    localparam int N_RANDOM   = 200;
    localparam int N_STREAM   = 100;
    localparam int MAX_CYCLES = 2 * (N_DIRECTED + N_RANDOM + N_STREAM) + 100;

    typedef struct packed {
        logic                     is_rep;
        logic                     is_opsize_override;
        x86_dec_pkg::seg_t        seg;
        x86_dec_pkg::pfx_count_t  num_prefixes;
        x86_dec_pkg::pfx_onehot_t num_prefixes_onehot;
        x86_dec_pkg::byte_t       opcode;
        x86_dec_pkg::byte_t       modrm;
    } result_t;

    logic                     clk;
    logic                     arst_n;
    x86_dec_pkg::packet_t     packet;
    logic                     in_valid;
    logic                     in_ready;
    logic                     out_valid;
    logic                     out_ready;
    logic                     is_rep;
    logic                     is_opsize_override;
    x86_dec_pkg::seg_t        seg;
    x86_dec_pkg::pfx_count_t  num_prefixes;
    x86_dec_pkg::pfx_onehot_t num_prefixes_onehot;
    x86_dec_pkg::byte_t       opcode;
    x86_dec_pkg::byte_t       modrm;

    result_t exp_q [$];             // expected results, oldest first
    int      cyc_q [$];             // acceptance cycle of each entry
    int      cycles     = 0;
    int      mon_errors = 0;
    int      mon_checks = 0;
    logic    took       = 1'b0;     // input accepted at the last rising edge
    int      drv_errors;
    int      sent_total;
    logic    streaming;
    logic    rand_ready;

    x86_decode_top i_x86_decode_top (
        .clk                 (clk),
        .arst_n              (arst_n),
        .packet              (packet),
        .in_valid            (in_valid),
        .in_ready            (in_ready),
        .out_valid           (out_valid),
        .out_ready           (out_ready),
        .is_rep              (is_rep),
        .is_opsize_override  (is_opsize_override),
        .seg                 (seg),
        .num_prefixes        (num_prefixes),
        .num_prefixes_onehot (num_prefixes_onehot),
        .opcode              (opcode),
        .modrm               (modrm)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic x86_dec_pkg::byte_t prefix_code(input int k);
        case (k)
            0:       return x86_dec_pkg::PFX_REP;
            1:       return x86_dec_pkg::PFX_CS;
            2:       return x86_dec_pkg::PFX_SS;
            3:       return x86_dec_pkg::PFX_DS;
            4:       return x86_dec_pkg::PFX_ES;
            5:       return x86_dec_pkg::PFX_FS;
            6:       return x86_dec_pkg::PFX_GS;
            default: return x86_dec_pkg::PFX_OPSIZE;
        endcase
    endfunction

    // a prefix half the time, any byte otherwise
    function automatic x86_dec_pkg::byte_t mixed_byte();
        if ($urandom % 2 == 0) begin
            return prefix_code(int'($urandom % 8));
        end
        return x86_dec_pkg::byte_t'($urandom);
    endfunction

    function automatic x86_dec_pkg::packet_t make_packet(input x86_dec_pkg::byte_t b0,
                                                         input x86_dec_pkg::byte_t b1,
                                                         input x86_dec_pkg::byte_t b2,
                                                         input x86_dec_pkg::byte_t b3);
        x86_dec_pkg::packet_t p;
        for (int i = 0; i < 16; i++) begin
            p[8*i +: 8] = x86_dec_pkg::byte_t'($urandom);
        end
        p[127:96] = {b0, b1, b2, b3};  // first byte on top
        return p;
    endfunction

    function automatic x86_dec_pkg::packet_t random_packet();
        return make_packet(mixed_byte(), mixed_byte(), mixed_byte(), mixed_byte());
    endfunction

    function automatic result_t expected_decode(input x86_dec_pkg::packet_t p);
        result_t            r;
        x86_dec_pkg::byte_t b;
        int                 n;
        logic               run;
        r     = '0;
        r.seg = x86_dec_pkg::SEG_DS;  // no override
        n     = 0;
        run   = 1'b1;
        for (int i = 0; i < x86_dec_pkg::MAX_PREFIXES; i++) begin
            b = p[127-8*i -: 8];
            if (run) begin
                case (b)
                    x86_dec_pkg::PFX_REP:    r.is_rep = 1'b1;
                    x86_dec_pkg::PFX_OPSIZE: r.is_opsize_override = 1'b1;
                    x86_dec_pkg::PFX_ES:     r.seg = x86_dec_pkg::SEG_ES;
                    x86_dec_pkg::PFX_CS:     r.seg = x86_dec_pkg::SEG_CS;
                    x86_dec_pkg::PFX_SS:     r.seg = x86_dec_pkg::SEG_SS;
                    x86_dec_pkg::PFX_DS:     r.seg = x86_dec_pkg::SEG_DS;
                    x86_dec_pkg::PFX_FS:     r.seg = x86_dec_pkg::SEG_FS;
                    x86_dec_pkg::PFX_GS:     r.seg = x86_dec_pkg::SEG_GS;
                    default:                 run = 1'b0;  // run ends here
                endcase
                if (run) n++;
            end
        end
        r.num_prefixes        = x86_dec_pkg::pfx_count_t'(n);
        r.num_prefixes_onehot = x86_dec_pkg::pfx_onehot_t'(1 << n);
        r.opcode              = p[127-8*n -: 8];
        r.modrm               = p[119-8*n -: 8];
        return r;
    endfunction

    function automatic int total_errors();
        return mon_errors + drv_errors;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        mon_checks++;
        assert (got == exp)
        else begin
            $display("ERR %s got %0h expected %0h", name, got, exp);
            mon_errors++;
        end
    endtask

    task automatic drive_ready();
        out_ready = rand_ready ? ($urandom % 2 == 0) : 1'b1;
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_packet(input x86_dec_pkg::packet_t p);
        int waited;
        waited   = 0;
        packet   = p;
        in_valid = 1'b1;
        do begin
            drive_ready();
            @(negedge clk);
            waited++;
        end while (!took);
        sent_total++;
        assert (!streaming || waited == 1)
        else begin
            $display("input stalled for %0d cycles while streaming", waited - 1);
            drv_errors++;
        end
    endtask

    task automatic drain();
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            drive_ready();
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name, input int sent, input int e0);
        $display("test %s done: %0d packets, %0d errors", name, sent, total_errors() - e0);
    endtask

    always @(posedge clk) begin : monitor
        result_t exp_r;
        int      acc_cyc;
        cycles++;
        if (out_valid && out_ready) begin
            assert (exp_q.size() != 0)
            else begin
                $display("output transfer at cycle %0d with no packet outstanding", cycles);
                mon_errors++;
            end
            if (exp_q.size() != 0) begin
                exp_r   = exp_q.pop_front();
                acc_cyc = cyc_q.pop_front();
                check_field("is_rep", 32'(is_rep), 32'(exp_r.is_rep));
                check_field("is_opsize_override", 32'(is_opsize_override),
                            32'(exp_r.is_opsize_override));
                check_field("seg", 32'(seg), 32'(exp_r.seg));
                check_field("num_prefixes", 32'(num_prefixes), 32'(exp_r.num_prefixes));
                check_field("num_prefixes_onehot", 32'(num_prefixes_onehot),
                            32'(exp_r.num_prefixes_onehot));
                check_field("opcode", 32'(opcode), 32'(exp_r.opcode));
                check_field("modrm", 32'(modrm), 32'(exp_r.modrm));
                if (streaming) begin
                    assert (cycles == acc_cyc + 1)
                    else begin
                        $display("output came %0d cycles after acceptance while streaming",
                                 cycles - acc_cyc);
                        mon_errors++;
                    end
                end
            end
        end
        took = in_valid && in_ready;
        if (took) begin
            exp_q.push_back(expected_decode(packet));
            cyc_q.push_back(cycles);
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin : stimulus
        int                   e0;
        x86_dec_pkg::packet_t p;
        void'($urandom(32'h65a556e6));
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        packet     = '0;
        out_ready  = 1'b1;
        streaming  = 1'b0;
        rand_ready = 1'b0;
        drv_errors = 0;
        sent_total = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (in_ready == 1'b1)
        else begin
            $display("ERR in_ready after reset got %0h expected 1", in_ready);
            drv_errors++;
        end
        assert (out_valid == 1'b0)
        else begin
            $display("ERR out_valid after reset got %0h expected 0", out_valid);
            drv_errors++;
        end

        e0 = total_errors();
        send_packet(make_packet(8'h90, 8'h8B, 8'hC3, 8'h00));  // no prefix
        for (int k = 0; k < 8; k++) begin
            send_packet(make_packet(prefix_code(k), 8'h8B, 8'h45, 8'h10));
        end
        send_packet(make_packet(x86_dec_pkg::PFX_REP, x86_dec_pkg::PFX_OPSIZE,
                                x86_dec_pkg::PFX_FS, 8'hA5));
        // fourth prefix is beyond the limit
        send_packet(make_packet(x86_dec_pkg::PFX_CS, x86_dec_pkg::PFX_SS,
                                x86_dec_pkg::PFX_OPSIZE, x86_dec_pkg::PFX_REP));
        drain();
        end_test("directed prefixes", 11, e0);

        e0 = total_errors();
        send_packet(make_packet(8'hF3, 8'h90, 8'h66, 8'h01));
        send_packet(make_packet(8'h66, 8'h26, 8'h8B, 8'hF3));
        drain();
        end_test("run stop", 2, e0);

        e0 = total_errors();
        send_packet(make_packet(8'h2E, 8'h64, 8'h65, 8'h8B));  // last is GS
        send_packet(make_packet(8'h36, 8'h36, 8'h8B, 8'h00));
        send_packet(make_packet(8'h3E, 8'h26, 8'h90, 8'h64));  // 64 is opcode side
        send_packet(make_packet(8'h66, 8'hF3, 8'h90, 8'h00));  // stays DS
        drain();
        end_test("segment select", 4, e0);

        e0 = total_errors();
        for (int n = 0; n <= x86_dec_pkg::MAX_PREFIXES; n++) begin
            p = random_packet();
            for (int i = 0; i < n; i++) begin
                p[127-8*i -: 8] = prefix_code(int'($urandom % 8));
            end
            p[127-8*n -: 8] = 8'h8B;
            p[119-8*n -: 8] = x86_dec_pkg::byte_t'(8'hC0 + n);
            send_packet(p);
        end
        drain();
        end_test("opcode align", 4, e0);

        e0         = total_errors();
        rand_ready = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_packet(random_packet());
        end
        drain();
        rand_ready = 1'b0;
        end_test("random back-pressure", N_RANDOM, e0);

        e0        = total_errors();
        streaming = 1'b1;
        for (int i = 0; i < N_STREAM; i++) begin
            send_packet(random_packet());
        end
        drain();
        streaming = 1'b0;
        end_test("streaming", N_STREAM, e0);

        $display("tests 6, packets %0d, field checks %0d, errors %0d",
                 sent_total, mon_checks, total_errors());
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- src.f
x86_dec_pkg.sv
prefix_cmp.sv
prefix_decode.sv
opcode_align.sv
decode_stage.sv
x86_decode_top.sv
x86_decode_props.sv
x86_decode_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = x86_decode_tb
FILELIST  = src.f
PASS_MSG  = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
